/* src/sfp_opb_pkg.sv */
`default_nettype none

package sfp_opb_pkg;

  // Slave region on the OPB
  localparam logic [31:0] OPB_BASEADDR = 32'h8000_1000;
  localparam logic [31:0] OPB_HIGHADDR = 32'h8000_101F;

  // GPIO window first, MDIO window right behind it
  localparam logic [31:0] GPIO_SPAN = 32'd16;

  // GPIO window offsets
  localparam logic [3:0] GPIO_OUT_OFS = 4'd0;
  localparam logic [3:0] GPIO_OE_OFS  = 4'd4;
  localparam logic [3:0] GPIO_DED_OFS = 4'd8;
  localparam logic [3:0] GPIO_IN_OFS  = 4'd12;

  // MDIO window offsets
  localparam logic [3:0] MDIO_CMD_OFS   = 4'd0;
  localparam logic [3:0] MDIO_CTRL_OFS  = 4'd4;
  localparam logic [3:0] MDIO_RDATA_OFS = 4'd8;

endpackage

`default_nettype wire

/* src/sfp_mgt_pkg.sv */
`default_nettype none

package sfp_mgt_pkg;

  localparam int GPIO_COUNT = 12;

  // SFP site 0
  localparam int PIN_EN0   = 0;
  localparam int PIN_RST0A = 1;
  localparam int PIN_RST0B = 2;
  localparam int PIN_MDC0  = 3;
  localparam int PIN_MDIO0 = 4;

  // SFP site 1
  localparam int PIN_EN1   = 6;
  localparam int PIN_RST1A = 7;
  localparam int PIN_RST1B = 8;
  localparam int PIN_MDC1  = 9;
  localparam int PIN_MDIO1 = 10;

  // MDC runs at OPB_Clk / (2 * MDC_HALF)
  localparam int MDC_HALF      = 4;
  localparam int PREAMBLE_BITS = 32;
  localparam int FRAME_BITS    = 32;

  // Clause 45 opcodes
  localparam logic [1:0] MDIO_OP_ADDR  = 2'b00;
  localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
  localparam logic [1:0] MDIO_OP_READ  = 2'b11;
  localparam logic [1:0] MDIO_OP_RINC  = 2'b10;

  // Command word, sent MSB first
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [1:0]  st;
      logic [1:0]  op;
      logic [4:0]  prtad;
      logic [4:0]  devad;
      logic [1:0]  ta;
      logic [15:0] data;
    } f;
  } mdio_cmd_u;

endpackage

`default_nettype wire

/* src/opb_slave_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module opb_slave_decode (
  input  wire         OPB_Clk,
  input  wire         wb_rst_i,
  input  wire         opb_select_i,
  input  wire         opb_rnw_i,
  input  wire  [31:0] opb_abus_i,
  input  wire  [31:0] opb_dbus_i,
  input  wire  [31:0] gpio_rdata_i,
  input  wire  [31:0] mdio_rdata_i,
  input  wire         cmd_reject_i,
  output logic        gpio_wr_o,
  output logic        mdio_wr_o,
  output logic        mdio_rd_o,
  output logic [3:0]  reg_ofs_o,
  output logic [31:0] reg_wdata_o,
  output logic [31:0] sl_dbus_o,
  output logic        sl_xfer_ack_o,
  output logic        sl_err_ack_o,
  output logic        sl_retry_o,
  output logic        sl_tout_sup_o
);
  import sfp_opb_pkg::*;

  logic        select_q;
  logic        start;
  logic        in_gpio;
  logic        in_mdio;
  logic        gpio_hit;
  logic        mdio_hit;
  logic        gpio_map;
  logic        gpio_wok;
  logic        mdio_map;
  logic        mdio_wok;
  logic        bad;
  logic        rd_gpio_q;
  logic        rd_mdio_q;
  logic [31:0] ofs_full;

  // New transfer on the rising edge of select
  assign start   = opb_select_i & ~select_q;
  assign in_gpio = (opb_abus_i >= OPB_BASEADDR) && (opb_abus_i < OPB_BASEADDR + GPIO_SPAN);
  assign in_mdio = (opb_abus_i >= OPB_BASEADDR + GPIO_SPAN) && (opb_abus_i <= OPB_HIGHADDR);
  assign gpio_hit = start & in_gpio;
  assign mdio_hit = start & in_mdio;

  assign ofs_full  = opb_abus_i - (in_mdio ? OPB_BASEADDR + GPIO_SPAN : OPB_BASEADDR);
  assign reg_ofs_o = ofs_full[3:0];
  assign reg_wdata_o = opb_dbus_i;

  assign gpio_map = reg_ofs_o inside {GPIO_OUT_OFS, GPIO_OE_OFS, GPIO_DED_OFS, GPIO_IN_OFS};
  assign gpio_wok = reg_ofs_o inside {GPIO_OUT_OFS, GPIO_OE_OFS, GPIO_DED_OFS};
  assign mdio_map = reg_ofs_o inside {MDIO_CMD_OFS, MDIO_CTRL_OFS, MDIO_RDATA_OFS};
  assign mdio_wok = reg_ofs_o inside {MDIO_CMD_OFS, MDIO_CTRL_OFS};

  assign gpio_wr_o = gpio_hit & ~opb_rnw_i & gpio_wok;
  assign mdio_wr_o = mdio_hit & ~opb_rnw_i & mdio_wok;
  assign mdio_rd_o = mdio_hit & opb_rnw_i & mdio_map;

  // Unmapped offset, write to a read-only register or busy command
  assign bad = (gpio_hit & (~gpio_map | (~opb_rnw_i & ~gpio_wok))) |
               (mdio_hit & (~mdio_map | (~opb_rnw_i & ~mdio_wok) | cmd_reject_i));

  always_ff @(posedge OPB_Clk) begin
    if (wb_rst_i) begin
      select_q      <= 1'b0;
      sl_xfer_ack_o <= 1'b0;
      sl_err_ack_o  <= 1'b0;
      rd_gpio_q     <= 1'b0;
      rd_mdio_q     <= 1'b0;
    end else begin
      select_q      <= opb_select_i;
      sl_xfer_ack_o <= (gpio_hit | mdio_hit) & ~bad;
      sl_err_ack_o  <= (gpio_hit | mdio_hit) & bad;
      rd_gpio_q     <= gpio_hit & opb_rnw_i & ~bad;
      rd_mdio_q     <= mdio_hit & opb_rnw_i & ~bad;
    end
  end

  // Bus stays zero except during a read acknowledge
  assign sl_dbus_o = rd_gpio_q ? gpio_rdata_i :
                     rd_mdio_q ? mdio_rdata_i : 32'd0;

  assign sl_retry_o    = 1'b0;
  assign sl_tout_sup_o = 1'b0;

  a_one_ack: assert property (@(posedge OPB_Clk) disable iff (wb_rst_i)
    !(sl_xfer_ack_o && sl_err_ack_o))
    else $error("xfer and err acknowledge together");

  a_ack_pulse: assert property (@(posedge OPB_Clk) disable iff (wb_rst_i)
    (sl_xfer_ack_o || sl_err_ack_o) |=> !(sl_xfer_ack_o || sl_err_ack_o))
    else $error("acknowledge longer than one cycle");

endmodule

`default_nettype wire

/* src/mgt_gpio_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module mgt_gpio_regs (
  input  wire                                  OPB_Clk,
  input  wire                                  wb_rst_i,
  input  wire                                  gpio_wr_i,
  input  wire  [3:0]                           reg_ofs_i,
  input  wire  [31:0]                          reg_wdata_i,
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0]   gpio_in_i,
  output logic [31:0]                          gpio_rdata_o,
  output logic [sfp_mgt_pkg::GPIO_COUNT-1:0]   gpio_out_o,
  output logic [sfp_mgt_pkg::GPIO_COUNT-1:0]   gpio_oe_o,
  output logic [sfp_mgt_pkg::GPIO_COUNT-1:0]   gpio_ded_o
);
  import sfp_opb_pkg::*;
  import sfp_mgt_pkg::*;

  logic                  wr_q;
  logic [3:0]            ofs_q;
  logic [GPIO_COUNT-1:0] wdata_q;
  logic [GPIO_COUNT-1:0] in_meta;
  logic [GPIO_COUNT-1:0] in_sync;
  logic [GPIO_COUNT-1:0] rd_sel;

  // Writes are staged one cycle so they land after the acknowledge
  always_ff @(posedge OPB_Clk) begin
    if (wb_rst_i) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= gpio_wr_i;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    ofs_q   <= reg_ofs_i;
    wdata_q <= reg_wdata_i[GPIO_COUNT-1:0];
  end

  always_ff @(posedge OPB_Clk) begin
    if (wb_rst_i) begin
      gpio_out_o <= '0;
      gpio_oe_o  <= '0;
      gpio_ded_o <= '0;
    end else if (wr_q) begin
      case (ofs_q)
        GPIO_OUT_OFS: gpio_out_o <= wdata_q;
        GPIO_OE_OFS:  gpio_oe_o  <= wdata_q;
        GPIO_DED_OFS: gpio_ded_o <= wdata_q;
        default: ;
      endcase
    end
  end

  // Two-flop synchronizer on the pad inputs
  always_ff @(posedge OPB_Clk) begin
    in_meta <= gpio_in_i;
    in_sync <= in_meta;
  end

  always_comb begin
    case (reg_ofs_i)
      GPIO_OUT_OFS: rd_sel = gpio_out_o;
      GPIO_OE_OFS:  rd_sel = gpio_oe_o;
      GPIO_DED_OFS: rd_sel = gpio_ded_o;
      GPIO_IN_OFS:  rd_sel = in_sync;
      default:      rd_sel = '0;
    endcase
  end

  // Registered so the data lines up with the acknowledge cycle
  always_ff @(posedge OPB_Clk) begin
    gpio_rdata_o <= {{(32-GPIO_COUNT){1'b0}}, rd_sel};
  end

endmodule

`default_nettype wire

/* src/mdio_master.sv */
`timescale 1ns/1ns
`default_nettype none

module mdio_master (
  input  wire         OPB_Clk,
  input  wire         wb_rst_i,
  input  wire         mdio_wr_i,
  input  wire         mdio_rd_i,
  input  wire  [3:0]  reg_ofs_i,
  input  wire  [31:0] reg_wdata_i,
  input  wire         mdi_i,
  output logic        mdc_o,
  output logic        mdo_o,
  output logic        mdo_en_o,
  output logic        site_sel_o,
  output logic        cmd_reject_o,
  output logic [31:0] mdio_rdata_o
);
  import sfp_opb_pkg::*;
  import sfp_mgt_pkg::*;

  logic                                         busy;
  logic                                         rd_op;
  logic                                         tick;
  logic                                         cmd_wr;
  logic                                         ctrl_wr;
  logic [$clog2(MDC_HALF)-1:0]                  div_cnt;
  logic [$clog2(PREAMBLE_BITS+FRAME_BITS+1)-1:0] bit_cnt;
  logic [PREAMBLE_BITS+FRAME_BITS-1:0]          shift_q;
  logic [15:0]                                  rdata_q;
  mdio_cmd_u                                    cmd_in;
  mdio_cmd_u                                    cmd_q;

  // Clause 45 start sequence is always 00
  always_comb begin
    cmd_in.raw  = reg_wdata_i;
    cmd_in.f.st = 2'b00;
  end

  assign cmd_wr       = mdio_wr_i && (reg_ofs_i == MDIO_CMD_OFS);
  assign cmd_reject_o = cmd_wr && busy;
  assign ctrl_wr      = mdio_wr_i && (reg_ofs_i == MDIO_CTRL_OFS) && !busy;
  assign tick         = busy && (div_cnt == MDC_HALF - 1);

  // Frame sequencer, one bit per MDC period
  always_ff @(posedge OPB_Clk) begin
    if (wb_rst_i) begin
      busy     <= 1'b0;
      rd_op    <= 1'b0;
      mdc_o    <= 1'b1;
      mdo_o    <= 1'b1;
      mdo_en_o <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else if (cmd_wr && !busy) begin
      busy    <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
      unique case (cmd_in.f.op)
        MDIO_OP_ADDR, MDIO_OP_WRITE: rd_op <= 1'b0;
        MDIO_OP_READ, MDIO_OP_RINC:  rd_op <= 1'b1;
      endcase
    end else if (busy) begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (tick && mdc_o) begin
        if (bit_cnt == PREAMBLE_BITS + FRAME_BITS) begin
          // Last high half done
          busy     <= 1'b0;
          mdo_o    <= 1'b1;
          mdo_en_o <= 1'b0;
        end else begin
          mdc_o    <= 1'b0;
          mdo_o    <= shift_q[PREAMBLE_BITS+FRAME_BITS-1];
          // Reads let go of the line from the second TA bit
          mdo_en_o <= !(rd_op && (bit_cnt >= PREAMBLE_BITS + 15));
          bit_cnt  <= bit_cnt + 1'b1;
        end
      end else if (tick) begin
        mdc_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (cmd_wr && !busy) begin
      shift_q <= {{PREAMBLE_BITS{1'b1}}, cmd_in.raw};
      cmd_q   <= cmd_in;
    end else if (tick && mdc_o && (bit_cnt != PREAMBLE_BITS + FRAME_BITS)) begin
      shift_q <= {shift_q[PREAMBLE_BITS+FRAME_BITS-2:0], 1'b0};
    end
  end

  // Sample the PHY data bits on the rising MDC edge
  always_ff @(posedge OPB_Clk) begin
    if (tick && !mdc_o && rd_op && (bit_cnt > PREAMBLE_BITS + 16)) begin
      rdata_q <= {rdata_q[14:0], mdi_i};
    end
  end

  // Site select is ignored while a frame runs
  always_ff @(posedge OPB_Clk) begin
    if (wb_rst_i) begin
      site_sel_o <= 1'b0;
    end else if (ctrl_wr) begin
      site_sel_o <= reg_wdata_i[0];
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (mdio_rd_i) begin
      case (reg_ofs_i)
        MDIO_CMD_OFS:   mdio_rdata_o <= cmd_q.raw;
        MDIO_CTRL_OFS:  mdio_rdata_o <= {30'd0, busy, site_sel_o};
        MDIO_RDATA_OFS: mdio_rdata_o <= {16'd0, rdata_q};
        default:        mdio_rdata_o <= 32'd0;
      endcase
    end
  end

  a_site_stable: assert property (@(posedge OPB_Clk) disable iff (wb_rst_i)
    busy |=> $stable(site_sel_o))
    else $error("site_sel changed during an MDIO frame");

endmodule

`default_nettype wire

/* src/mgt_pin_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module mgt_pin_mux (
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] gpio_out_i,
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] gpio_oe_i,
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] gpio_ded_i,
  input  wire                                mdc_i,
  input  wire                                mdo_i,
  input  wire                                mdo_en_i,
  input  wire                                site_sel_i,
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_i,
  output logic                               mdi_o,
  output logic [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_o,
  output logic [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_oe_o
);
  import sfp_mgt_pkg::*;

  logic [GPIO_COUNT-1:0] ded_out;
  logic [GPIO_COUNT-1:0] ded_oe;
  logic                  mdio_pull;

  always_comb begin
    // Open drain, only a zero bit pulls the line
    mdio_pull = mdo_en_i & ~mdo_i;
    ded_out   = '0;
    ded_oe    = '0;
    ded_out[PIN_EN0]   = 1'b1;
    ded_out[PIN_EN1]   = 1'b1;
    ded_oe[PIN_EN0]    = 1'b1;
    ded_oe[PIN_EN1]    = 1'b1;
    ded_oe[PIN_RST0A]  = 1'b1;
    ded_oe[PIN_RST0B]  = 1'b1;
    ded_oe[PIN_RST1A]  = 1'b1;
    ded_oe[PIN_RST1B]  = 1'b1;
    // Idle site keeps MDC high
    ded_out[PIN_MDC0]  = site_sel_i ? 1'b1 : mdc_i;
    ded_out[PIN_MDC1]  = site_sel_i ? mdc_i : 1'b1;
    ded_oe[PIN_MDC0]   = 1'b1;
    ded_oe[PIN_MDC1]   = 1'b1;
    ded_oe[PIN_MDIO0]  = mdio_pull & ~site_sel_i;
    ded_oe[PIN_MDIO1]  = mdio_pull & site_sel_i;

    mgt_gpio_o    = (gpio_ded_i & ded_out) | (~gpio_ded_i & gpio_out_i);
    mgt_gpio_oe_o = (gpio_ded_i & ded_oe) | (~gpio_ded_i & gpio_oe_i);

    if (gpio_ded_i[PIN_MDIO0]) begin
      assert (mgt_gpio_o[PIN_MDIO0] == 1'b0) else $error("MDIO0 pin driven high");
    end
    if (gpio_ded_i[PIN_MDIO1]) begin
      assert (mgt_gpio_o[PIN_MDIO1] == 1'b0) else $error("MDIO1 pin driven high");
    end
  end

  assign mdi_o = site_sel_i ? mgt_gpio_i[PIN_MDIO1] : mgt_gpio_i[PIN_MDIO0];

endmodule

`default_nettype wire

/* src/sfp_mdio_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sfp_mdio_ctrl_top (
  input  wire                                OPB_Clk,
  input  wire                                wb_rst_i,
  input  wire                                opb_select_i,
  input  wire                                opb_rnw_i,
  input  wire  [3:0]                         opb_be_i,
  input  wire  [31:0]                        opb_abus_i,
  input  wire  [31:0]                        opb_dbus_i,
  output wire  [31:0]                        sl_dbus_o,
  output wire                                sl_xfer_ack_o,
  output wire                                sl_err_ack_o,
  output wire                                sl_retry_o,
  output wire                                sl_tout_sup_o,
  input  wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_i,
  output wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_o,
  output wire  [sfp_mgt_pkg::GPIO_COUNT-1:0] mgt_gpio_oe_o
);
  import sfp_opb_pkg::*;
  import sfp_mgt_pkg::*;

  wire                  gpio_wr;
  wire                  mdio_wr;
  wire                  mdio_rd;
  wire [3:0]            reg_ofs;
  wire [31:0]           reg_wdata;
  wire [31:0]           gpio_rdata;
  wire [31:0]           mdio_rdata;
  wire                  cmd_reject;
  wire [GPIO_COUNT-1:0] gpio_out;
  wire [GPIO_COUNT-1:0] gpio_oe;
  wire [GPIO_COUNT-1:0] gpio_ded;
  wire                  mdc;
  wire                  mdo;
  wire                  mdo_en;
  wire                  site_sel;
  wire                  mdi;

  opb_slave_decode u_decode (
    .OPB_Clk       (OPB_Clk),
    .wb_rst_i      (wb_rst_i),
    .opb_select_i  (opb_select_i),
    .opb_rnw_i     (opb_rnw_i),
    .opb_abus_i    (opb_abus_i),
    .opb_dbus_i    (opb_dbus_i),
    .gpio_rdata_i  (gpio_rdata),
    .mdio_rdata_i  (mdio_rdata),
    .cmd_reject_i  (cmd_reject),
    .gpio_wr_o     (gpio_wr),
    .mdio_wr_o     (mdio_wr),
    .mdio_rd_o     (mdio_rd),
    .reg_ofs_o     (reg_ofs),
    .reg_wdata_o   (reg_wdata),
    .sl_dbus_o     (sl_dbus_o),
    .sl_xfer_ack_o (sl_xfer_ack_o),
    .sl_err_ack_o  (sl_err_ack_o),
    .sl_retry_o    (sl_retry_o),
    .sl_tout_sup_o (sl_tout_sup_o)
  );

  mgt_gpio_regs u_gpio (
    .OPB_Clk      (OPB_Clk),
    .wb_rst_i     (wb_rst_i),
    .gpio_wr_i    (gpio_wr),
    .reg_ofs_i    (reg_ofs),
    .reg_wdata_i  (reg_wdata),
    .gpio_in_i    (mgt_gpio_i),
    .gpio_rdata_o (gpio_rdata),
    .gpio_out_o   (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .gpio_ded_o   (gpio_ded)
  );

  mdio_master u_mdio (
    .OPB_Clk      (OPB_Clk),
    .wb_rst_i     (wb_rst_i),
    .mdio_wr_i    (mdio_wr),
    .mdio_rd_i    (mdio_rd),
    .reg_ofs_i    (reg_ofs),
    .reg_wdata_i  (reg_wdata),
    .mdi_i        (mdi),
    .mdc_o        (mdc),
    .mdo_o        (mdo),
    .mdo_en_o     (mdo_en),
    .site_sel_o   (site_sel),
    .cmd_reject_o (cmd_reject),
    .mdio_rdata_o (mdio_rdata)
  );

  mgt_pin_mux u_mux (
    .gpio_out_i    (gpio_out),
    .gpio_oe_i     (gpio_oe),
    .gpio_ded_i    (gpio_ded),
    .mdc_i         (mdc),
    .mdo_i         (mdo),
    .mdo_en_i      (mdo_en),
    .site_sel_i    (site_sel),
    .mgt_gpio_i    (mgt_gpio_i),
    .mdi_o         (mdi),
    .mgt_gpio_o    (mgt_gpio_o),
    .mgt_gpio_oe_o (mgt_gpio_oe_o)
  );

  // All registers are 32 bits wide, so writes into the region use every byte lane
  a_full_word_write: assert property (@(posedge OPB_Clk) disable iff (wb_rst_i)
    opb_select_i && !opb_rnw_i && (opb_abus_i >= OPB_BASEADDR) &&
    (opb_abus_i <= OPB_HIGHADDR) |-> opb_be_i == 4'hF)
    else $error("partial write into the register region");

endmodule

`default_nettype wire

/* sim/mdio_phy_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mdio_phy_model (
  input  wire         mdc_i,
  input  wire         mdio_i,
  input  wire  [15:0] reply_i,
  output logic        mdio_pull_o,
  output logic [63:0] last_frame_o,
  output logic [7:0]  frame_count_o,
  output logic        conflict_o
);
  logic [63:0] hist       = '0;
  logic [63:0] frame_q    = '0;
  logic [7:0]  count_q    = '0;
  logic        conflict_q = 1'b0;
  logic        pull_q     = 1'b0;
  logic        in_frame   = 1'b0;
  logic        rd_frame   = 1'b0;
  logic        drive_bit  = 1'b1;
  int          fpos       = 0;

  always @(mdc_i) begin
    if (mdc_i === 1'b1) begin
      // Line is sampled on the rising MDC edge
      if (in_frame && rd_frame && (fpos >= 15) && (mdio_i !== drive_bit)) begin
        conflict_q = 1'b1;
      end
      hist = {hist[62:0], mdio_i};
      if (in_frame) begin
        fpos = fpos + 1;
        if (fpos == 4) begin
          rd_frame = hist[1];
        end
        if (fpos == 32) begin
          in_frame = 1'b0;
          frame_q  = hist;
          count_q  = count_q + 8'd1;
          pull_q   = 1'b0;
        end
      end else if (hist[33:0] == {32'hFFFF_FFFF, 2'b00}) begin
        // At least 32 preamble ones, then the 00 start
        in_frame = 1'b1;
        rd_frame = 1'b0;
        fpos     = 2;
      end
    end else if (mdc_i === 1'b0) begin
      // Read answer changes after the falling edge, second TA bit low
      if (in_frame && rd_frame && (fpos >= 15)) begin
        drive_bit = (fpos == 15) ? 1'b0 : reply_i[31 - fpos];
        pull_q    = ~drive_bit;
      end
    end
  end

  assign mdio_pull_o   = pull_q;
  assign last_frame_o  = frame_q;
  assign frame_count_o = count_q;
  assign conflict_o    = conflict_q;

endmodule

`default_nettype wire

/* sim/tb_sfp_mdio_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sfp_mdio_ctrl;
  import sfp_opb_pkg::*;
  import sfp_mgt_pkg::*;

  localparam int          ACK_TIMEOUT  = 16;
  localparam int          BUSY_TIMEOUT = 400;
  localparam logic [31:0] GPIO_BASE    = OPB_BASEADDR;
  localparam logic [31:0] MDIO_BASE    = OPB_BASEADDR + GPIO_SPAN;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  opb_select;
  logic                  opb_rnw;
  logic [3:0]            opb_be;
  logic [31:0]           opb_abus;
  logic [31:0]           opb_dbus;
  wire  [31:0]           sl_dbus;
  wire                   sl_xfer_ack;
  wire                   sl_err_ack;
  wire                   sl_retry;
  wire                   sl_tout_sup;
  wire  [GPIO_COUNT-1:0] gpio_o;
  wire  [GPIO_COUNT-1:0] gpio_oe;
  logic [GPIO_COUNT-1:0] pins;
  logic [GPIO_COUNT-1:0] ext_in;
  wire                   phy0_pull;
  wire                   phy1_pull;
  wire  [63:0]           phy0_frame;
  wire  [63:0]           phy1_frame;
  wire  [7:0]            phy0_count;
  wire  [7:0]            phy1_count;
  wire                   phy0_conflict;
  wire                   phy1_conflict;
  logic [15:0]           reply0;
  logic [15:0]           reply1;

  // Expected state kept by the stimulus
  int                    ack_kind;
  logic                  rd_chk;
  logic [31:0]           rd_expect;
  logic                  pin_chk;
  logic [GPIO_COUNT-1:0] exp_out;
  logic [GPIO_COUNT-1:0] exp_oe;
  logic [GPIO_COUNT-1:0] exp_ded;
  logic                  site0_quiet;
  logic                  site1_quiet;
  logic                  chk_frames;
  logic [63:0]           exp_frame0;
  logic [63:0]           exp_frame1;
  logic [7:0]            exp_count0;
  logic [7:0]            exp_count1;
  logic [31:0]           seed;
  int                    fail_count;
  int                    other_errors;

  always #10 clk = ~clk;

  sfp_mdio_ctrl_top dut0 (
    .OPB_Clk       (clk),
    .wb_rst_i      (rst),
    .opb_select_i  (opb_select),
    .opb_rnw_i     (opb_rnw),
    .opb_be_i      (opb_be),
    .opb_abus_i    (opb_abus),
    .opb_dbus_i    (opb_dbus),
    .sl_dbus_o     (sl_dbus),
    .sl_xfer_ack_o (sl_xfer_ack),
    .sl_err_ack_o  (sl_err_ack),
    .sl_retry_o    (sl_retry),
    .sl_tout_sup_o (sl_tout_sup),
    .mgt_gpio_i    (pins),
    .mgt_gpio_o    (gpio_o),
    .mgt_gpio_oe_o (gpio_oe)
  );

  // Pad resolution with pull-ups and the open-drain PHY pull-downs
  always_comb begin
    pins = (gpio_oe & gpio_o) | (~gpio_oe & ext_in);
    if (phy0_pull) begin
      pins[PIN_MDIO0] = 1'b0;
    end
    if (phy1_pull) begin
      pins[PIN_MDIO1] = 1'b0;
    end
  end

  mdio_phy_model phy0 (
    .mdc_i         (pins[PIN_MDC0]),
    .mdio_i        (pins[PIN_MDIO0]),
    .reply_i       (reply0),
    .mdio_pull_o   (phy0_pull),
    .last_frame_o  (phy0_frame),
    .frame_count_o (phy0_count),
    .conflict_o    (phy0_conflict)
  );

  mdio_phy_model phy1 (
    .mdc_i         (pins[PIN_MDC1]),
    .mdio_i        (pins[PIN_MDIO1]),
    .reply_i       (reply1),
    .mdio_pull_o   (phy1_pull),
    .last_frame_o  (phy1_frame),
    .frame_count_o (phy1_count),
    .conflict_o    (phy1_conflict)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic count_fail(input string msg);
    fail_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> !sl_xfer_ack && !sl_err_ack && (gpio_oe == '0))
    else count_fail("outputs not idle after reset");

  a_xfer_kind: assert property (@(posedge clk) disable iff (rst)
    sl_xfer_ack |-> ack_kind == 1)
    else count_fail("unexpected sl_xfer_ack_o");

  a_err_kind: assert property (@(posedge clk) disable iff (rst)
    sl_err_ack |-> ack_kind == 2)
    else count_fail("unexpected sl_err_ack_o");

  a_no_retry: assert property (@(posedge clk) !sl_retry && !sl_tout_sup)
    else count_fail("sl_retry_o or sl_tout_sup_o high");

  a_read_data: assert property (@(posedge clk) disable iff (rst)
    sl_xfer_ack && rd_chk |-> sl_dbus == rd_expect)
    else count_fail("wrong read data on sl_dbus_o");

  // Register writes show on the pins one cycle after the acknowledge
  a_gpio_pins: assert property (@(posedge clk) disable iff (rst)
    sl_xfer_ack && pin_chk |=> (((gpio_o ^ exp_out) & ~exp_ded) == '0) &&
    (((gpio_oe ^ exp_oe) & ~exp_ded) == '0))
    else count_fail("GPIO pins differ from the written registers");

  a_site1_idle: assert property (@(posedge clk) disable iff (rst)
    site1_quiet |-> pins[PIN_MDC1] && !gpio_oe[PIN_MDIO1])
    else count_fail("site 1 MDC or MDIO active during a site 0 frame");

  a_site0_idle: assert property (@(posedge clk) disable iff (rst)
    site0_quiet |-> pins[PIN_MDC0] && !gpio_oe[PIN_MDIO0])
    else count_fail("site 0 MDC or MDIO active during a site 1 frame");

  a_frame0: assert property (@(posedge clk) disable iff (rst)
    chk_frames |-> (phy0_count == exp_count0) && (phy0_frame == exp_frame0))
    else count_fail("site 0 PHY frame mismatch");

  a_frame1: assert property (@(posedge clk) disable iff (rst)
    chk_frames |-> (phy1_count == exp_count1) && (phy1_frame == exp_frame1))
    else count_fail("site 1 PHY frame mismatch");

  a_no_conflict: assert property (@(posedge clk)
    !$rose(phy0_conflict) && !$rose(phy1_conflict))
    else count_fail("MDIO line driven during the PHY data phase");

  task automatic opb_access(input logic rnw, input logic [31:0] addr,
                            input logic [31:0] wdata, input int kind, input logic chk,
                            input logic [31:0] expect_rd, output logic [31:0] rdata);
    int   waited;
    logic got;
    waited     = 0;
    got        = 1'b0;
    rdata      = 32'd0;
    ack_kind   = kind;
    rd_chk     = chk;
    rd_expect  = expect_rd;
    opb_select = 1'b1;
    opb_rnw    = rnw;
    opb_abus   = addr;
    opb_dbus   = rnw ? 32'd0 : wdata;
    while (!got && (waited < ACK_TIMEOUT)) begin
      @(posedge clk);
      #2;
      waited++;
      if (sl_xfer_ack || sl_err_ack) begin
        got   = 1'b1;
        rdata = sl_dbus;
      end
    end
    opb_select = 1'b0;
    opb_rnw    = 1'b1;
    opb_abus   = 32'd0;
    opb_dbus   = 32'd0;
    if (!got && (kind != 0)) begin
      other_errors++;
      $display("Error at %0t: no acknowledge for address %h within %0d cycles",
               $time, addr, ACK_TIMEOUT);
    end
    // Idle gap so checks on this transfer finish before the next one
    repeat (2) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input int kind);
    logic [31:0] unused_rd;
    opb_access(1'b0, addr, data, kind, 1'b0, 32'd0, unused_rd);
  endtask

  task automatic write_gpio(input logic [3:0] ofs, input logic [31:0] data);
    case (ofs)
      GPIO_OUT_OFS: exp_out = data[GPIO_COUNT-1:0];
      GPIO_OE_OFS:  exp_oe  = data[GPIO_COUNT-1:0];
      GPIO_DED_OFS: exp_ded = data[GPIO_COUNT-1:0];
      default: ;
    endcase
    pin_chk = 1'b1;
    write_reg(GPIO_BASE + ofs, data, 1);
    pin_chk = 1'b0;
  endtask

  task automatic wait_mdio_idle();
    logic [31:0] status;
    logic        busy;
    int          polls;
    busy  = 1'b1;
    polls = 0;
    while (busy && (polls < BUSY_TIMEOUT)) begin
      opb_access(1'b1, MDIO_BASE + MDIO_CTRL_OFS, 32'd0, 1, 1'b0, 32'd0, status);
      busy = status[1];
      polls++;
    end
    if (busy) begin
      other_errors++;
      $display("Error at %0t: MDIO busy still set after %0d polls", $time, polls);
    end
  endtask

  task automatic check_frames();
    chk_frames = 1'b1;
    @(posedge clk);
    #2;
    chk_frames = 1'b0;
  endtask

  initial begin
    logic [31:0] val;
    logic [31:0] rd;
    logic [31:0] cmd;
    int          i;
    rst          = 1'b1;
    opb_select   = 1'b0;
    opb_rnw      = 1'b1;
    opb_be       = 4'hF;
    opb_abus     = 32'd0;
    opb_dbus     = 32'd0;
    ext_in       = '1;
    reply0       = 16'h0000;
    reply1       = 16'h0000;
    ack_kind     = 0;
    rd_chk       = 1'b0;
    rd_expect    = 32'd0;
    pin_chk      = 1'b0;
    exp_out      = '0;
    exp_oe       = '0;
    exp_ded      = '0;
    site0_quiet  = 1'b0;
    site1_quiet  = 1'b0;
    chk_frames   = 1'b0;
    exp_frame0   = '0;
    exp_frame1   = '0;
    exp_count0   = 8'd0;
    exp_count1   = 8'd0;
    seed         = 32'habbdfcb1;
    fail_count   = 0;
    other_errors = 0;

    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;

    // GPIO output and enable registers
    for (i = 0; i < 6; i++) begin
      val = next_rand();
      write_gpio(GPIO_OUT_OFS, val);
      opb_access(1'b1, GPIO_BASE + GPIO_OUT_OFS, 32'd0, 1, 1'b1, {20'd0, val[11:0]}, rd);
      val = next_rand();
      write_gpio(GPIO_OE_OFS, val);
      opb_access(1'b1, GPIO_BASE + GPIO_OE_OFS, 32'd0, 1, 1'b1, {20'd0, val[11:0]}, rd);
    end

    // GPIO inputs with every output disabled
    write_gpio(GPIO_OE_OFS, 32'd0);
    for (i = 0; i < 3; i++) begin
      val    = next_rand();
      ext_in = val[GPIO_COUNT-1:0];
      repeat (4) @(posedge clk);
      #2;
      opb_access(1'b1, GPIO_BASE + GPIO_IN_OFS, 32'd0, 1, 1'b1, {20'd0, val[11:0]}, rd);
    end
    ext_in = '1;

    // Write frame on site 0, plus a command rejected while busy
    write_gpio(GPIO_DED_OFS, 32'h0000_0FFF);
    write_reg(MDIO_BASE + MDIO_CTRL_OFS, 32'd0, 1);
    cmd        = next_rand();
    cmd[31:28] = {2'b00, MDIO_OP_WRITE};
    exp_frame0 = {32'hFFFF_FFFF, cmd};
    site1_quiet = 1'b1;
    write_reg(MDIO_BASE + MDIO_CMD_OFS, cmd, 1);
    write_reg(MDIO_BASE + MDIO_CMD_OFS, next_rand(), 2);
    wait_mdio_idle();
    site1_quiet = 1'b0;
    exp_count0  = 8'd1;
    check_frames();

    // Read frame on site 1
    write_reg(MDIO_BASE + MDIO_CTRL_OFS, 32'd1, 1);
    val        = next_rand();
    reply1     = val[15:0];
    cmd        = next_rand();
    cmd[31:28] = {2'b00, MDIO_OP_READ};
    cmd[17:16] = 2'b10;
    exp_frame1 = {32'hFFFF_FFFF, cmd[31:17], 1'b0, reply1};
    site0_quiet = 1'b1;
    write_reg(MDIO_BASE + MDIO_CMD_OFS, cmd, 1);
    wait_mdio_idle();
    site0_quiet = 1'b0;
    exp_count1  = 8'd1;
    check_frames();
    opb_access(1'b1, MDIO_BASE + MDIO_RDATA_OFS, 32'd0, 1, 1'b1, {16'd0, reply1}, rd);

    // Error acknowledges
    opb_access(1'b1, MDIO_BASE + 32'd12, 32'd0, 2, 1'b0, 32'd0, rd);
    write_reg(GPIO_BASE + GPIO_IN_OFS, next_rand(), 2);
    write_reg(MDIO_BASE + MDIO_RDATA_OFS, next_rand(), 2);

    // Outside the region nothing answers
    opb_access(1'b1, OPB_HIGHADDR + 32'd4, 32'd0, 0, 1'b0, 32'd0, rd);
    write_reg(OPB_BASEADDR - 32'd4, next_rand(), 0);

    repeat (4) @(posedge clk);
    $display("Checks failed: %0d, other errors: %0d", fail_count, other_errors);
    if ((fail_count == 0) && (other_errors == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/sfp_opb_pkg.sv
src/sfp_mgt_pkg.sv
src/opb_slave_decode.sv
src/mgt_gpio_regs.sv
src/mdio_master.sv
src/mgt_pin_mux.sv
src/sfp_mdio_ctrl_top.sv
sim/mdio_phy_model.sv
sim/tb_sfp_mdio_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_sfp_mdio_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sfp_mdio_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
